//--- filelist.f
+incdir+src
src/lvds_tester_pkg.sv
src/lane_stat_if.sv
src/test_ctrl.sv
src/prbs_gen.sv
src/prbs_check.sv
src/lvds_io_tester.sv
verif/tb_checker.sv
verif/tb_lvds_io_tester.sv

//--- verif/tb_lvds_io_tester.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module tb_lvds_io_tester;

  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_RDERR = 2;
  localparam int OP_WRERR = 3;
  localparam int OP_POLL  = 4;
  localparam int OP_FLIP  = 5;

  logic        clk;
  logic        reset;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [30:0] pad_ctrl;
  logic [1:0]  lane_a_dout;
  logic [1:0]  lane_b_dout;
  logic [1:0]  lane_a_din;
  logic [1:0]  lane_b_din;
  logic [1:0]  flip_a;
  logic [1:0]  flip_b;
  logic [31:0] rng;
  int          chk_checks;
  int          chk_errors;
  int          errors;
  int          n_rows;
  string       t_label [64];
  int          t_op    [64];
  logic [7:0]  t_addr  [64];
  logic [31:0] t_data  [64];
  logic        t_chk   [64];
  logic [31:0] t_exp   [64];
  int          t_idle  [64];

  lvds_io_tester dut (
    .clk         (clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .pad_ctrl    (pad_ctrl),
    .lane_a_dout (lane_a_dout),
    .lane_b_dout (lane_b_dout),
    .lane_a_din  (lane_a_din),
    .lane_b_din  (lane_b_din)
  );

  tb_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .pad_ctrl    (pad_ctrl),
    .lane_a_dout (lane_a_dout),
    .lane_b_dout (lane_b_dout),
    .lane_a_din  (lane_a_din),
    .lane_b_din  (lane_b_din),
    .n_checks    (chk_checks),
    .n_errors    (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Loopback, with a one-shot flip mask per lane.
  always @(negedge clk) begin
    lane_a_din <= lane_a_dout ^ flip_a;
    lane_b_din <= lane_b_dout ^ flip_b;
    flip_a     = 2'b00;
    flip_b     = 2'b00;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic add(input string label, input int op, input logic [7:0] addr,
                     input logic [31:0] data, input logic chk, input logic [31:0] exp,
                     input int idle);
    t_label[n_rows] = label;
    t_op[n_rows]    = op;
    t_addr[n_rows]  = addr;
    t_data[n_rows]  = data;
    t_chk[n_rows]   = chk;
    t_exp[n_rows]   = exp;
    t_idle[n_rows]  = idle;
    n_rows++;
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 16) fail_now("Timeout: pready never came during an APB access.");
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic inject_flip(input int lane);
    int   waited;
    logic [1:0] mask;
    repeat (rng % 4) @(negedge clk);
    mask = rng[8] ? 2'b10 : 2'b01;
    rng  = xorshift(rng);
    @(posedge clk);
    if (lane == 0) flip_a = mask;
    else flip_b = mask;
    waited = 0;
    while ((flip_a | flip_b) != 2'b00) begin
      @(posedge clk);
      waited++;
      if (waited > 4) fail_now("Timeout: the loopback did not apply a bit flip.");
    end
  endtask

  task automatic run_row(input int r);
    logic [31:0] rd;
    logic        err;
    int          tries;
    case (t_op[r])
      OP_WR: apb_access(1'b1, t_addr[r], t_data[r], rd, err);
      OP_WRERR, OP_RDERR: begin
        apb_access(t_op[r] == OP_WRERR, t_addr[r], t_data[r], rd, err);
        if (err !== 1'b1) begin
          errors++;
          $display("No pslverr at t=%0t for unmapped address %h.", $time, t_addr[r]);
        end
      end
      OP_RD: begin
        apb_access(1'b0, t_addr[r], '0, rd, err);
        if (t_chk[r] && rd !== t_exp[r]) begin
          errors++;
          $display("MISMATCH t=%0t prdata[%h] got %h expected %h",
                   $time, t_addr[r], rd, t_exp[r]);
        end
      end
      OP_POLL: begin
        tries = 0;
        do begin
          apb_access(1'b0, t_addr[r], '0, rd, err);
          tries++;
          if (tries > 100) fail_now("Timeout: the lanes never reached the lock state.");
        end while (rd !== t_exp[r]);
      end
      default: inject_flip(int'(t_data[r]));
    endcase
    repeat (t_idle[r]) @(negedge clk);
  endtask

  initial begin
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    flip_a  = 2'b00;
    flip_b  = 2'b00;
    lane_a_din = 2'b00;
    lane_b_din = 2'b00;
    rng     = 32'd67431;
    errors  = 0;
    n_rows  = 0;

    add("reset CTRL",      OP_RD,    8'h00, 0, 1, 0, 0);
    add("reset PAD_CFG",   OP_RD,    8'h04, 0, 1, 0, 0);
    add("reset STATUS",    OP_RD,    8'h08, 0, 1, 0, 0);
    add("reset RECV_A",    OP_RD,    8'h10, 0, 1, 0, 0);
    add("reset RECV_B",    OP_RD,    8'h14, 0, 1, 0, 0);
    add("reset ERR_A",     OP_RD,    8'h18, 0, 1, 0, 0);
    add("reset ERR_B",     OP_RD,    8'h1C, 0, 1, 0, 0);
    add("pad write",       OP_WR,    8'h04, 32'h2B3C4D5E, 0, 0, 1);
    add("pad readback",    OP_RD,    8'h04, 0, 1, 32'h2B3C4D5E, 0);
    add("unmapped read",   OP_RDERR, 8'h20, 0, 0, 0, 0);
    add("unmapped write",  OP_WRERR, 8'h0C, 32'hFFFFFFFF, 0, 0, 0);
    add("pad unchanged",   OP_RD,    8'h04, 0, 1, 32'h2B3C4D5E, 0);
    add("run on",          OP_WR,    8'h00, 32'h1, 0, 0, 0);
    add("wait lock",       OP_POLL,  8'h08, 0, 1, 32'h3, 20);
    add("count A",         OP_RD,    8'h10, 0, 0, 0, 5);
    add("count B",         OP_RD,    8'h14, 0, 0, 0, 0);
    add("no errors A",     OP_RD,    8'h18, 0, 1, 0, 0);
    add("no errors B",     OP_RD,    8'h1C, 0, 1, 0, 0);
    add("flip A",          OP_FLIP,  8'h00, 0, 0, 0, 12);
    add("err A after 1",   OP_RD,    8'h18, 0, 1, 3, 0);
    add("err B untouched", OP_RD,    8'h1C, 0, 1, 0, 0);
    add("flip B",          OP_FLIP,  8'h00, 1, 0, 0, 12);
    add("err B after 1",   OP_RD,    8'h1C, 0, 1, 3, 0);
    add("err A still 3",   OP_RD,    8'h18, 0, 1, 3, 0);
    add("flip A again",    OP_FLIP,  8'h00, 0, 0, 0, 12);
    add("err A after 2",   OP_RD,    8'h18, 0, 1, 6, 0);
    add("clear",           OP_WR,    8'h00, 32'h3, 0, 0, 0);
    add("err A cleared",   OP_RD,    8'h18, 0, 1, 0, 0);
    add("recv A cleared",  OP_RD,    8'h10, 0, 1, 0, 0);
    add("relock",          OP_POLL,  8'h08, 0, 1, 32'h3, 10);
    add("recount A",       OP_RD,    8'h10, 0, 0, 0, 0);
    add("stop and invert", OP_WR,    8'h00, 32'h6, 0, 0, 2);
    add("run inverted",    OP_WR,    8'h00, 32'h7, 0, 0, 0);
    add("lock inverted",   OP_POLL,  8'h08, 0, 1, 32'h3, 20);
    add("inv errors A",    OP_RD,    8'h18, 0, 1, 0, 0);
    add("inv errors B",    OP_RD,    8'h1C, 0, 1, 0, 0);
    add("inv count B",     OP_RD,    8'h14, 0, 0, 0, 0);

    repeat (5) @(negedge clk);
    reset = 1'b0;
    if (pad_ctrl !== 31'd0) begin
      errors++;
      $display("MISMATCH t=%0t pad_ctrl got %h expected %h", $time, pad_ctrl, 31'd0);
    end

    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
      $display("row %0d %s done, errors so far %0d", r, t_label[r], errors + chk_errors);
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", chk_checks, errors + chk_errors);
    if (errors + chk_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #200us;
    $display("Timeout: the simulation ran past its time limit.");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module tb_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`LVDS_APB_AW-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  input  logic [31:0]             prdata,
  input  logic                    pready,
  input  logic                    pslverr,
  input  logic [30:0]             pad_ctrl,
  input  logic [`LVDS_LANE_W-1:0] lane_a_dout,
  input  logic [`LVDS_LANE_W-1:0] lane_b_dout,
  input  logic [`LVDS_LANE_W-1:0] lane_a_din,
  input  logic [`LVDS_LANE_W-1:0] lane_b_din,
  output int                      n_checks,
  output int                      n_errors
);

  import lvds_tester_pkg::*;

  logic [1:0]  dq      [2];
  logic [6:0]  hist    [2];
  int          match   [2];
  logic [15:0] win     [2];
  logic        lock    [2];
  logic [31:0] recv    [2];
  logic [31:0] errc    [2];
  logic        m_run;
  logic        m_clear;
  logic        m_inv;
  logic [30:0] m_pad;
  logic [6:0]  gen_state;
  logic [1:0]  gen_out;

  function automatic string reg_name(input logic [7:0] a);
    case (a)
      8'h00:   return "CTRL";
      8'h04:   return "PAD_CFG";
      8'h08:   return "STATUS";
      8'h10:   return "RECV_A";
      8'h14:   return "RECV_B";
      8'h18:   return "ERR_A";
      8'h1C:   return "ERR_B";
      default: return "UNMAPPED";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expected_read(input logic [7:0] a, output logic [31:0] v,
                               output logic mapped);
    mapped = 1'b1;
    v      = '0;
    case (a)
      8'h00:   v = {29'd0, m_inv, m_clear, m_run};
      8'h04:   v = {1'b0, m_pad};
      8'h08:   v = {30'd0, lock[1], lock[0]};
      8'h10:   v = recv[0];
      8'h14:   v = recv[1];
      8'h18:   v = errc[0];
      8'h1C:   v = errc[1];
      default: mapped = 1'b0;
    endcase
  endtask

  // Serial x^7 + x^6 + 1 LFSR, two bits per clock, oldest bit first.
  task automatic step_gen();
    logic [1:0] pair;
    for (int k = 1; k >= 0; k--) begin
      pair[k]   = gen_state[6];
      gen_state = {gen_state[5:0], gen_state[6] ^ gen_state[5]};
    end
    gen_out = pair ^ {2{m_inv}};
  endtask

  // One clock of the checker model; bit 1 of each pair is the older bit.
  task automatic step_lane(input int i, input logic [1:0] d);
    logic [6:0]  h;
    logic [15:0] nwin;
    logic [32:0] sum;
    logic        bit_v;
    logic        mis;
    int          cnt;
    int          nmis;
    int          ones;
    h    = hist[i];
    nwin = win[i];
    cnt  = match[i];
    nmis = 0;
    for (int k = 1; k >= 0; k--) begin
      bit_v = dq[i][k];
      mis   = bit_v ^ h[5] ^ h[6] ^ m_inv; // Bits 6 and 7 back.
      if (mis) begin
        nmis++;
        cnt = 0;
      end else if (cnt < 7) begin
        cnt++;
      end
      nwin = {nwin[14:0], mis};
      h    = {h[5:0], bit_v};
    end
    if (hist[i] == {7{m_inv}}) cnt = 0;  // Stuck line never locks.
    ones = 0;
    for (int k = 0; k < 16; k++) ones += nwin[k];
    if (m_clear) begin
      lock[i]  = 1'b0;
      match[i] = 0;
      win[i]   = '0;
      recv[i]  = '0;
      errc[i]  = '0;
    end else if (!lock[i]) begin
      match[i] = cnt;
      lock[i]  = (cnt == 7);
      win[i]   = '0;
    end else begin
      win[i] = nwin;
      if (ones >= 4) begin
        lock[i]  = 1'b0;
        match[i] = 0;
      end
      if (m_run) begin
        recv[i] = recv[i] + 2;
        sum     = {1'b0, errc[i]} + nmis;
        errc[i] = sum[32] ? 32'hFFFF_FFFF : sum[31:0];
      end
    end
    hist[i] = h;
    dq[i]   = d;
  endtask

  initial begin
    n_checks = 0;
    n_errors = 0;
  end

  always @(posedge clk) begin
    logic [31:0] ev;
    logic        em;
    if (reset) begin
      for (int i = 0; i < 2; i++) begin
        dq[i]    = '0;
        hist[i]  = '0;
        match[i] = 0;
        win[i]   = '0;
        lock[i]  = 1'b0;
        recv[i]  = '0;
        errc[i]  = '0;
      end
      m_run     = 1'b0;
      m_clear   = 1'b0;
      m_inv     = 1'b0;
      m_pad     = '0;
      gen_state = 7'h7F;                    // All-ones seed.
      gen_out   = '0;
    end else begin
      compare("pad_ctrl", {1'b0, pad_ctrl}, {1'b0, m_pad});
      compare("lane_a_dout", {30'd0, lane_a_dout}, {30'd0, gen_out});
      compare("lane_b_dout", {30'd0, lane_b_dout}, {30'd0, gen_out});
      if (psel && penable) begin
        expected_read(paddr, ev, em);
        compare("pready", {31'd0, pready}, 32'd1); // No wait states.
        compare("pslverr", {31'd0, pslverr}, {31'd0, !em});
        if (!pwrite) compare(reg_name(paddr), prdata, ev);
      end
      if (m_run) step_gen();
      step_lane(0, lane_a_din);
      step_lane(1, lane_b_din);
      m_clear = 1'b0;                       // Clear is a one-cycle pulse.
      if (psel && penable && pwrite && paddr == CTRL) begin
        m_run   = pwdata[0];
        m_clear = pwdata[1];
        m_inv   = pwdata[2];
      end
      if (psel && penable && pwrite && paddr == PAD_CFG) m_pad = pwdata[30:0];
    end
  end

endmodule

//--- src/lvds_io_tester.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module lvds_io_tester (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`LVDS_APB_AW-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic [30:0]             pad_ctrl,
  output logic [`LVDS_LANE_W-1:0] lane_a_dout,
  output logic [`LVDS_LANE_W-1:0] lane_b_dout,
  input  logic [`LVDS_LANE_W-1:0] lane_a_din,
  input  logic [`LVDS_LANE_W-1:0] lane_b_din
);

  logic run;
  logic invert;

  lane_stat_if lane_if [`LVDS_LANES] ();

  test_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .pad_ctrl (pad_ctrl),
    .run      (run),
    .invert   (invert),
    .lane     (lane_if)
  );

  prbs_gen u_gen_a (
    .clk    (clk),
    .reset  (reset),
    .run    (run),
    .invert (invert),
    .dout   (lane_a_dout)
  );

  prbs_gen u_gen_b (
    .clk    (clk),
    .reset  (reset),
    .run    (run),
    .invert (invert),
    .dout   (lane_b_dout)
  );

  prbs_check u_chk_a (
    .clk   (clk),
    .reset (reset),
    .din   (lane_a_din),
    .stat  (lane_if[0])
  );

  prbs_check u_chk_b (
    .clk   (clk),
    .reset (reset),
    .din   (lane_b_din),
    .stat  (lane_if[1])
  );

endmodule

//--- src/prbs_check.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module prbs_check (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`LVDS_LANE_W-1:0] din,
  lane_stat_if.chk                stat
);

  logic [`LVDS_LANE_W-1:0] din_q;
  logic [6:0]              hist;         // Received bits, hist[0] newest.
  logic                    exp1;
  logic                    exp0;
  logic                    m1;
  logic                    m0;
  logic                    degen;
  logic [2:0]              match_cnt;
  logic [3:0]              match_sum;
  logic [2:0]              match_next;
  logic [15:0]             miss_win;
  logic [15:0]             miss_next;
  logic                    lock_q;
  logic [1:0]              n_err;
  logic [`LVDS_CNT_W:0]    err_sum;
  logic [`LVDS_CNT_W-1:0]  err_next;
  logic [`LVDS_CNT_W-1:0]  recv_q;
  logic [`LVDS_CNT_W-1:0]  err_q;

  // Inversion flips every predicted bit.
  assign exp1 = hist[5] ^ hist[6] ^ stat.invert;
  assign exp0 = hist[4] ^ hist[5] ^ stat.invert;
  assign m1   = din_q[1] ^ exp1;
  assign m0   = din_q[0] ^ exp0;

  // A stuck line also fits the rule, so it must not lock.
  assign degen = (hist == {7{stat.invert}});

  always_comb begin
    match_sum = {1'b0, match_cnt} + 4'd2;
    if (degen || m0) begin
      match_next = 3'd0;
    end else if (m1) begin
      match_next = 3'd1;
    end else if (match_sum >= 4'd7) begin
      match_next = 3'd7;
    end else begin
      match_next = match_sum[2:0];
    end
  end

  assign miss_next = {miss_win[13:0], m1, m0}; // Last 16 bits.

  assign n_err    = {1'b0, m1} + {1'b0, m0};
  assign err_sum  = {1'b0, err_q} + n_err;
  assign err_next = err_sum[`LVDS_CNT_W] ? '1 : err_sum[`LVDS_CNT_W-1:0]; // Saturate.

  always_ff @(posedge clk) begin
    if (reset) begin
      din_q     <= '0;
      hist      <= '0;
      lock_q    <= 1'b0;
      match_cnt <= '0;
      miss_win  <= '0;
      recv_q    <= '0;
      err_q     <= '0;
    end else begin
      din_q <= din;
      hist  <= {hist[4:0], din_q[1], din_q[0]};
      if (stat.clear) begin
        lock_q    <= 1'b0;
        match_cnt <= '0;
        miss_win  <= '0;
        recv_q    <= '0;
        err_q     <= '0;
      end else if (!lock_q) begin
        match_cnt <= match_next;
        lock_q    <= (match_next == 3'd7); // Seven good bits in a row.
        miss_win  <= '0;
      end else begin
        miss_win <= miss_next;
        if ($countones(miss_next) >= 4) begin
          lock_q    <= 1'b0;
          match_cnt <= '0;
        end
        if (stat.run) begin
          recv_q <= recv_q + `LVDS_LANE_W;
          err_q  <= err_next;
        end
      end
    end
  end

  assign stat.lock     = lock_q;
  assign stat.recv_cnt = recv_q;
  assign stat.err_cnt  = err_q;

endmodule

//--- src/prbs_gen.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module prbs_gen (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,
  input  logic                    invert,
  output logic [`LVDS_LANE_W-1:0] dout
);

  // lfsr[0] is the newest bit, lfsr[6] the oldest.
  logic [6:0] lfsr;
  logic [1:0] fb;

  // x^7 + x^6 + 1, two steps per clock.
  assign fb = {lfsr[5] ^ lfsr[6], lfsr[4] ^ lfsr[5]};

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= 7'h7F;                    // All-ones seed.
      dout <= '0;
    end else if (run) begin
      dout <= lfsr[6:5] ^ {`LVDS_LANE_W{invert}}; // Older bit in bit 1.
      lfsr <= {lfsr[4:0], fb};
    end
  end

endmodule

//--- src/test_ctrl.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

module test_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`LVDS_APB_AW-1:0]    paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  output lvds_tester_pkg::pad_ctrl_t pad_ctrl,
  output logic                       run,
  output logic                       invert,
  lane_stat_if.ctrl                  lane [`LVDS_LANES]
);

  import lvds_tester_pkg::*;

  ctrl_reg_t              ctrl_q;
  ctrl_reg_t              wr_ctrl;
  pad_ctrl_t              pad_q;
  logic                   access;
  logic                   wr_en;
  logic                   mapped;
  logic [31:0]            rd_data;
  logic [`LVDS_LANES-1:0] lock_v;
  logic [`LVDS_CNT_W-1:0] recv_v [`LVDS_LANES];
  logic [`LVDS_CNT_W-1:0] err_v  [`LVDS_LANES];

  // Interface array elements need constant indices.
  for (genvar i = 0; i < `LVDS_LANES; i++) begin : g_lane
    assign lane[i].run    = ctrl_q.run;
    assign lane[i].clear  = ctrl_q.clear;
    assign lane[i].invert = ctrl_q.invert;
    assign lock_v[i]      = lane[i].lock;
    assign recv_v[i]      = lane[i].recv_cnt;
    assign err_v[i]       = lane[i].err_cnt;
  end

  assign access  = psel & penable;      // No wait states.
  assign wr_en   = access & pwrite & mapped;
  assign wr_ctrl = ctrl_reg_t'(pwdata);

  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (reg_addr_e'(paddr))
      CTRL:    rd_data = ctrl_q;
      PAD_CFG: rd_data = {1'b0, pad_q};
      STATUS:  rd_data = 32'(lock_v);
      RECV_A:  rd_data = recv_v[0];
      RECV_B:  rd_data = recv_v[1];
      ERR_A:   rd_data = err_v[0];
      ERR_B:   rd_data = err_v[1];
      default: mapped  = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q <= '0;
      pad_q  <= '0;
    end else begin
      ctrl_q.clear <= 1'b0;             // Clear lasts one cycle.
      if (wr_en && paddr == CTRL) begin
        ctrl_q.run    <= wr_ctrl.run;
        ctrl_q.clear  <= wr_ctrl.clear;
        ctrl_q.invert <= wr_ctrl.invert;
      end
      if (wr_en && paddr == PAD_CFG) begin
        pad_q <= pad_ctrl_t'(pwdata[30:0]);
      end
    end
  end

  assign prdata   = (access && !pwrite) ? rd_data : '0;
  assign pready   = 1'b1;
  assign pslverr  = access & ~mapped;   // Unmapped address.
  assign pad_ctrl = pad_q;
  assign run      = ctrl_q.run;
  assign invert   = ctrl_q.invert;

endmodule

//--- src/lane_stat_if.sv
`timescale 1ns/1ps
`include "lvds_tester_macros.svh"

interface lane_stat_if;

  logic                   run;
  logic                   clear;    // One-cycle pulse.
  logic                   invert;
  logic                   lock;
  logic [`LVDS_CNT_W-1:0] recv_cnt;
  logic [`LVDS_CNT_W-1:0] err_cnt;

  modport ctrl (
    output run,
    output clear,
    output invert,
    input  lock,
    input  recv_cnt,
    input  err_cnt
  );

  modport chk (
    input  run,
    input  clear,
    input  invert,
    output lock,
    output recv_cnt,
    output err_cnt
  );

endinterface

//--- src/lvds_tester_pkg.sv
`include "lvds_tester_macros.svh"

package lvds_tester_pkg;

  // One pad group, MSB first in pad pin order.
  typedef struct packed {
    logic       sel_rx_a;
    logic       sel_rx_b;
    logic       sel_tx_a;
    logic       sel_tx_b;
    logic       pd_bias_a;
    logic       pd_bias_b;
    logic [1:0] idset_a;
    logic [1:0] idset_b;
    logic       hyst_a;
    logic       hyst_b;
    logic [1:0] drv_str_a;
    logic [1:0] drv_str_b;
    logic       sr_a;
    logic       sr_b;
    logic       puden_tx_a;
    logic       puden_tx_b;
    logic       puden_rx_a;
    logic       puden_rx_b;
    logic       pudpol_tx_a;
    logic       pudpol_tx_b;
    logic       pudpol_rx_a;
    logic       pudpol_rx_b;
    logic [1:0] test_a;
    logic [1:0] test_b;
    logic       por;
  } pad_ctrl_t;

  typedef struct packed {
    logic [28:0] rsvd;
    logic        invert; // Send the inverted pattern.
    logic        clear;  // Write one to clear the counters.
    logic        run;    // Generators on.
  } ctrl_reg_t;

  typedef enum logic [`LVDS_APB_AW-1:0] {
    CTRL    = 'h00,
    PAD_CFG = 'h04,
    STATUS  = 'h08,
    RECV_A  = 'h10,
    RECV_B  = 'h14,
    ERR_A   = 'h18,
    ERR_B   = 'h1C
  } reg_addr_e;

endpackage

//--- src/lvds_tester_macros.svh
`ifndef LVDS_TESTER_MACROS_SVH
`define LVDS_TESTER_MACROS_SVH

// Loopback lanes A and B.
`define LVDS_LANES 2

// Bits per lane per clock.
`define LVDS_LANE_W 2

// Received-bit and error counter width.
`define LVDS_CNT_W 32

// APB address width.
`define LVDS_APB_AW 8

`endif
